// File: hdl/drive_settings.svh
`ifndef DRIVE_SETTINGS_SVH
`define DRIVE_SETTINGS_SVH

// Data widths.
`define ERR_W      12     // Heading, desired heading and heading error.
`define SPD_W      11     // Signed wheel speed.
`define FRWRD_W    10     // Unsigned forward speed.

// PID gains.
`define P_COEFF    16     // Proportional gain.
`define D_COEFF    7      // Derivative gain.

// Move sequencer ramp.
`define FRWRD_MAX  10'h200  // Cruise forward speed.
`define RAMP_STEP  16       // Forward speed change per ramp tick.
`define RAMP_DIV   8        // Clock cycles per ramp tick.

// Motor drive.
`define PWM_PERIOD 1024   // Cycles per PWM frame.

`endif

// File: hdl/drive_pkg.sv
`include "drive_settings.svh"

////////////////////////////////////////////////////////////////////////////
// Types shared by the heading-hold drive core.
////////////////////////////////////////////////////////////////////////////
package drive_pkg;

	// Move sequencer states.
	typedef enum logic [1:0] {
		IDLE      = 2'b00,   // Stopped, forward speed is zero.
		RAMP_UP   = 2'b01,   // Forward speed climbing toward cruise.
		CRUISE    = 2'b10,   // Holding the cruise forward speed.
		RAMP_DOWN = 2'b11    // Forward speed falling toward zero.
	} move_state_e;

	// Signed heading error, wraps modulo 2^ERR_W.
	typedef logic signed [`ERR_W-1:0] err_t;

	// Signed wheel speed, negative drives the wheel backward.
	typedef logic signed [`SPD_W-1:0] spd_t;

endpackage

// File: hdl/pid_cmd_if.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

// Command bundle from the heading and move stages into the PID.
interface pid_cmd_if;
	import drive_pkg::*;

	err_t               error;    // Heading error, held between strobes.
	logic               err_vld;  // One cycle strobe per new error.
	logic               moving;   // Sequencer is outside IDLE.
	logic [`FRWRD_W-1:0] frwrd;   // Ramped forward speed.

	// Heading error stage.
	modport src_err (output error, output err_vld);

	// Move sequencer.
	modport src_move (output moving, output frwrd);

	// PID controller reads everything.
	modport sink (input error, input err_vld, input moving, input frwrd);

endinterface

// File: hdl/heading_err.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

// Heading error stage. One registered error per heading sample.
module heading_err (
	input  logic              clk,          // System clock.
	input  logic              rst_n,        // Asynchronous active low reset.
	input  logic [`ERR_W-1:0] heading,      // Measured heading sample.
	input  logic              heading_vld,  // Strobe for a new heading sample.
	input  logic [`ERR_W-1:0] desired_hdg,  // Heading the robot should hold.
	pid_cmd_if.src_err        cmd           // Error and strobe toward the PID.
);
	import drive_pkg::*;

	err_t err_q;      // Registered heading error.
	logic err_vld_q;  // Strobe, one cycle behind heading_vld.

	// Difference wraps naturally in ERR_W bits, so 0xFFF and 0x001 are 2 apart.
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			err_q     <= '0;
			err_vld_q <= 1'b0;
		end else begin
			err_vld_q <= heading_vld;  // Strobe follows the sample by one cycle.
			if (heading_vld)
				err_q <= err_t'(desired_hdg - heading);  // Held until next sample.
		end
	end

	assign cmd.error   = err_q;
	assign cmd.err_vld = err_vld_q;

	// A lone sample gives exactly one strobe, one cycle later.
	a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		heading_vld ##1 !heading_vld |-> err_vld_q ##1 !err_vld_q)
		else $error("heading_err strobe not a single cycle pulse.");

endmodule

// File: hdl/move_seq.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

// Move sequencer. Turns the level go command into a ramped forward speed.
module move_seq (
	input  logic        clk,    // System clock.
	input  logic        rst_n,  // Asynchronous active low reset.
	input  logic        go,     // Level drive command.
	pid_cmd_if.src_move cmd     // Moving flag and forward speed out.
);
	import drive_pkg::*;

	localparam int                  tick_w   = $clog2(`RAMP_DIV);
	localparam logic [`FRWRD_W-1:0] step_val = `RAMP_STEP;
	localparam logic [`FRWRD_W-1:0] max_val  = `FRWRD_MAX;

	move_state_e         state;      // Current state.
	move_state_e         state_nxt;  // Next state.
	logic [tick_w-1:0]   tick_cnt;   // Divides the clock down to the ramp rate.
	logic                ramp_tick;  // One cycle in RAMP_DIV.
	logic [`FRWRD_W:0]   frwrd_up;   // Forward speed plus one step, with carry.
	logic [`FRWRD_W-1:0] frwrd_q;    // Registered forward speed.
	logic [`FRWRD_W-1:0] frwrd_nxt;
	logic                moving_q;   // Registered moving flag.

	////////////////////////////////////////////////////////////////////////////
	// Ramp tick divider.
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if ((state == IDLE) || ramp_tick)
			tick_cnt <= '0;  // Restart each period, parked while stopped.
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign ramp_tick = (tick_cnt == tick_w'(`RAMP_DIV - 1));
	assign frwrd_up  = {1'b0, frwrd_q} + {1'b0, step_val};

	////////////////////////////////////////////////////////////////////////////
	// Next state and forward speed.
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_nxt = state;
		frwrd_nxt = frwrd_q;
		case (state)
			IDLE: begin
				frwrd_nxt = '0;
				if (go)
					state_nxt = RAMP_UP;
			end
			RAMP_UP: begin
				if (!go)
					state_nxt = RAMP_DOWN;
				else if (ramp_tick) begin
					// Clamp at cruise speed.
					frwrd_nxt = (frwrd_up >= {1'b0, max_val}) ? max_val : frwrd_up[`FRWRD_W-1:0];
					if (frwrd_nxt == max_val)
						state_nxt = CRUISE;
				end
			end
			CRUISE: begin
				if (!go)
					state_nxt = RAMP_DOWN;
			end
			RAMP_DOWN: begin
				if (go)
					state_nxt = RAMP_UP;  // Resume climbing from the current speed.
				else if (ramp_tick) begin
					frwrd_nxt = (frwrd_q <= step_val) ? '0 : (frwrd_q - step_val);  // Floor at zero.
					if (frwrd_nxt == '0)
						state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			frwrd_q  <= '0;
			moving_q <= 1'b0;
		end else begin
			state    <= state_nxt;
			frwrd_q  <= frwrd_nxt;
			moving_q <= (state_nxt != IDLE);  // Tracks the state register exactly.
		end
	end

	assign cmd.moving = moving_q;
	assign cmd.frwrd  = frwrd_q;

	a_frwrd_max: assert property (@(posedge clk) disable iff (!rst_n)
		frwrd_q <= max_val)
		else $error("move_seq forward speed above cruise.");

	a_moving_state: assert property (@(posedge clk) disable iff (!rst_n)
		moving_q == (state != IDLE))
		else $error("move_seq moving flag out of step with state.");

endmodule

// File: hdl/pid.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

// PID heading controller. Forms saturated left and right wheel speeds.
module pid (
	input  logic            clk,      // System clock.
	input  logic            rst_n,    // Asynchronous active low reset.
	pid_cmd_if.sink         cmd,      // Error, strobe, moving flag and forward speed.
	output drive_pkg::spd_t lft_spd,  // Left wheel speed.
	output drive_pkg::spd_t rght_spd  // Right wheel speed.
);
	import drive_pkg::*;

	localparam logic signed [5:0] p_gain = `P_COEFF;
	localparam logic signed [4:0] d_gain = `D_COEFF;

	// P term.
	logic signed [9:0]  err_sat;      // Error saturated to 10 bits.
	logic signed [13:0] p_term;
	// I term.
	logic signed [14:0] err_sat_ext;  // Saturated error widened to integrator size.
	logic signed [14:0] integ_sum;    // Candidate integrator value.
	logic               integ_ov;     // Candidate overflowed.
	logic signed [14:0] integ_nxt;
	logic signed [14:0] integrator;
	logic signed [8:0]  i_term;
	// D term.
	logic signed [9:0]  hist_0;       // Newest stored error.
	logic signed [9:0]  hist_1;
	logic signed [9:0]  hist_2;       // Oldest stored error.
	logic signed [10:0] d_diff;       // Full width difference, cannot wrap.
	logic signed [7:0]  d_diff_sat;
	logic signed [12:0] d_term;
	// Sum and wheel mix.
	logic signed [13:0] pid_term;
	spd_t               frwrd_ext;
	spd_t               lft_raw;
	spd_t               rght_raw;

	////////////////////////////////////////////////////////////////////////////
	// Proportional.
	////////////////////////////////////////////////////////////////////////////
	// Clamp to 0x1FF or 0x200 when the upper bits are not all sign.
	assign err_sat = (~cmd.error[`ERR_W-1] & |cmd.error[`ERR_W-2:9]) ? 10'sh1FF :
	                 (cmd.error[`ERR_W-1] & ~&cmd.error[`ERR_W-2:9]) ? 10'sh200 :
	                 cmd.error[9:0];

	assign p_term = err_sat * p_gain;  // Fits 14 bits for any 10 bit error.

	////////////////////////////////////////////////////////////////////////////
	// Integral.
	////////////////////////////////////////////////////////////////////////////
	assign err_sat_ext = {{5{err_sat[9]}}, err_sat};
	assign integ_sum   = integrator + err_sat_ext;

	// Overflow only when both addends share a sign and the sum flips it.
	assign integ_ov = (err_sat_ext[14] == integrator[14]) && (integ_sum[14] != err_sat_ext[14]);

	always_comb begin
		if (!cmd.moving)
			integ_nxt = '0;  // Wind down while stopped.
		else if (cmd.err_vld && !integ_ov)
			integ_nxt = integ_sum;
		else
			integ_nxt = integrator;  // Hold between strobes and at the limit.
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			integrator <= '0;
		else
			integrator <= integ_nxt;
	end

	assign i_term = integrator[14:6];  // Top 9 bits.

	////////////////////////////////////////////////////////////////////////////
	// Derivative.
	////////////////////////////////////////////////////////////////////////////
	// Three deep history, shifted on each strobe.
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			hist_0 <= '0;
			hist_1 <= '0;
			hist_2 <= '0;
		end else if (cmd.err_vld) begin
			hist_0 <= err_sat;
			hist_1 <= hist_0;
			hist_2 <= hist_1;
		end
	end

	assign d_diff = {err_sat[9], err_sat} - {hist_2[9], hist_2};

	// Saturate to 8 bits.
	assign d_diff_sat = (~d_diff[10] & |d_diff[9:7]) ? 8'sh7F :
	                    (d_diff[10] & ~&d_diff[9:7]) ? 8'sh80 :
	                    d_diff[7:0];

	assign d_term = d_diff_sat * d_gain;

	////////////////////////////////////////////////////////////////////////////
	// Sum and wheel mix.
	////////////////////////////////////////////////////////////////////////////
	// P/2 + I + D, all sign extended to 14 bits.
	assign pid_term = {p_term[13], p_term[13:1]} + {{5{i_term[8]}}, i_term} + {d_term[12], d_term};

	assign frwrd_ext = {1'b0, cmd.frwrd};  // Forward speed is never negative.

	assign lft_raw  = cmd.moving ? (frwrd_ext + pid_term[13:3]) : '0;
	assign rght_raw = cmd.moving ? (frwrd_ext - pid_term[13:3]) : '0;

	// Positive correction pushing left negative means it wrapped high.
	assign lft_spd  = (~pid_term[13] & lft_raw[10]) ? 11'sh3FF : lft_raw;
	// Same for the right wheel with the correction subtracted.
	assign rght_spd = (pid_term[13] & rght_raw[10]) ? 11'sh3FF : rght_raw;

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!cmd.moving |-> (lft_spd == '0) && (rght_spd == '0))
		else $error("pid wheel speeds nonzero while stopped.");

endmodule

// File: hdl/motor_pwm.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

// PWM motor drive for one wheel. Duty equals the speed magnitude.
module motor_pwm (
	input  logic            clk,    // System clock.
	input  logic            rst_n,  // Asynchronous active low reset.
	input  drive_pkg::spd_t spd,    // Signed wheel speed.
	output logic            pwm,    // Motor enable pulse.
	output logic            dir     // High for reverse.
);
	localparam int cnt_w = $clog2(`PWM_PERIOD);

	logic [cnt_w-1:0]  frm_cnt;   // Free running frame counter.
	logic              frm_last;  // Last cycle of the frame.
	logic [`SPD_W-1:0] spd_abs;   // Magnitude of the incoming speed.
	logic [`SPD_W-1:0] spd_mag;   // Magnitude held for the current frame.
	logic              dir_q;

	assign frm_last = (frm_cnt == cnt_w'(`PWM_PERIOD - 1));

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			frm_cnt <= '0;
		else if (frm_last)
			frm_cnt <= '0;
		else
			frm_cnt <= frm_cnt + 1'b1;
	end

	// Full negative speed maps to 2^(SPD_W-1), which still fits unsigned.
	assign spd_abs = spd[`SPD_W-1] ? `SPD_W'(-spd) : spd;

	////////////////////////////////////////////////////////////////////////////
	// Speed sample, taken on the edge into count zero.
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			spd_mag <= '0;
			dir_q   <= 1'b0;
		end else if (frm_last) begin
			spd_mag <= spd_abs;
			dir_q   <= spd[`SPD_W-1];  // Sign picks the direction.
		end
	end

	// High for spd_mag cycles per frame, always high at full scale.
	assign pwm = ({1'b0, frm_cnt} < spd_mag);
	assign dir = dir_q;

endmodule

// File: hdl/drive_ctrl_top.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

// Heading-hold drive core. Heading sample to wheel speed in 2 cycles.
module drive_ctrl_top (
	input  logic              clk,          // System clock.
	input  logic              rst_n,        // Asynchronous active low reset.
	input  logic              go,           // Level drive command.
	input  logic [`ERR_W-1:0] heading,      // Measured heading sample.
	input  logic              heading_vld,  // Strobe for a new heading sample.
	input  logic [`ERR_W-1:0] desired_hdg,  // Heading to hold.
	output drive_pkg::spd_t   lft_spd,      // Left wheel speed.
	output drive_pkg::spd_t   rght_spd,     // Right wheel speed.
	output logic              lft_pwm,      // Left motor PWM.
	output logic              lft_dir,      // Left motor direction.
	output logic              rght_pwm,     // Right motor PWM.
	output logic              rght_dir      // Right motor direction.
);

	pid_cmd_if cmd_if ();  // Error and motion command into the PID.

	////////////////////////////////////////////////////////////////////////////
	// Command stages.
	////////////////////////////////////////////////////////////////////////////
	heading_err heading_err_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.heading     (heading),
		.heading_vld (heading_vld),
		.desired_hdg (desired_hdg),
		.cmd         (cmd_if)
	);

	move_seq move_seq_i (
		.clk   (clk),
		.rst_n (rst_n),
		.go    (go),
		.cmd   (cmd_if)
	);

	////////////////////////////////////////////////////////////////////////////
	// Controller and motor drive.
	////////////////////////////////////////////////////////////////////////////
	pid pid_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd      (cmd_if),
		.lft_spd  (lft_spd),
		.rght_spd (rght_spd)
	);

	motor_pwm lft_pwm_i (.clk(clk), .rst_n(rst_n), .spd(lft_spd), .pwm(lft_pwm), .dir(lft_dir));

	motor_pwm rght_pwm_i (.clk(clk), .rst_n(rst_n), .spd(rght_spd), .pwm(rght_pwm), .dir(rght_dir));

endmodule

// File: testbench/tb_drive_ctrl.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

module tb_drive_ctrl;

	localparam int st_idle      = 0;  // Sequencer states of the reference model.
	localparam int st_ramp_up   = 1;
	localparam int st_cruise    = 2;
	localparam int st_ramp_down = 3;

	logic                     clk = 1'b0;
	logic                     rst_n, go, heading_vld;
	logic [`ERR_W-1:0]        heading, desired_hdg;
	logic signed [`SPD_W-1:0] lft_spd, rght_spd;
	logic                     lft_pwm, lft_dir, rght_pwm, rght_dir;

	logic [15:0] lfsr;       // Stimulus LFSR state.
	bit          chk_en;     // Per cycle compare running.
	string       test_name;  // Current test, shown in error lines.
	int          ref_err, ref_integ, ref_state, ref_tick, ref_frwrd;  // Reference model.
	bit          ref_err_vld;
	int          ref_hist [3];  // Saturated errors, entry 2 is the oldest.

	drive_ctrl_top dut_i (.*);

	always #2 clk = ~clk;  // 4 ns period.

	////////////////////////////////////////////////////////////////////////////
	// Reference model.
	////////////////////////////////////////////////////////////////////////////
	function automatic int clamp(int v, int lo, int hi);
		return (v < lo) ? lo : (v > hi) ? hi : v;
	endfunction

	function automatic int magnitude(int v);
		return (v < 0) ? -v : v;
	endfunction

	// Wheel speed from the PID rules.
	function automatic int ref_speed(int err, int integ, int hist_old, int frwrd, bit moving,
			bit left);
		int e_sat, pid_sum, corr, spd;
		if (!moving)
			return 0;  // Stopped wheels.
		e_sat   = clamp(err, -512, 511);
		pid_sum = ((e_sat * `P_COEFF) >>> 1) + (integ >>> 6)
		        + clamp(e_sat - hist_old, -128, 127) * `D_COEFF;
		corr    = pid_sum >>> 3;  // Top 11 of 14 bits.
		spd     = left ? frwrd + corr : frwrd - corr;
		return (spd > 1023) ? 1023 : spd;  // Positive overflow clamp.
	endfunction

	function automatic int expect_spd(bit left);
		return ref_speed(ref_err, ref_integ, ref_hist[2], ref_frwrd, ref_state != st_idle, left);
	endfunction

	// Advance the model by one clock edge, using the inputs seen before the edge.
	task automatic model_edge();
		int  e_sat, sum, diff;
		bit  at_tick;
		e_sat = clamp(ref_err, -512, 511);
		sum   = ref_integ + e_sat;
		if (ref_state == st_idle)
			ref_integ = 0;  // Cleared while stopped.
		else if (ref_err_vld && sum <= 16383 && sum >= -16384)
			ref_integ = sum;  // Skipped on 15 bit overflow.
		if (ref_err_vld) begin
			ref_hist[2] = ref_hist[1];
			ref_hist[1] = ref_hist[0];
			ref_hist[0] = e_sat;
		end
		ref_err_vld = heading_vld;
		if (heading_vld) begin
			diff    = (int'(desired_hdg) - int'(heading)) & 'hFFF;  // Wraps modulo 2^12.
			ref_err = (diff >= 2048) ? diff - 4096 : diff;
		end
		at_tick  = (ref_tick == `RAMP_DIV - 1);
		ref_tick = (ref_state == st_idle || at_tick) ? 0 : ref_tick + 1;
		case (ref_state)
			st_idle: begin
				ref_frwrd = 0;
				ref_state = go ? st_ramp_up : st_idle;
			end
			st_ramp_up: begin
				if (!go)
					ref_state = st_ramp_down;
				else if (at_tick) begin
					ref_frwrd = clamp(ref_frwrd + `RAMP_STEP, 0, `FRWRD_MAX);
					ref_state = (ref_frwrd == `FRWRD_MAX) ? st_cruise : st_ramp_up;
				end
			end
			st_cruise:
				ref_state = go ? st_cruise : st_ramp_down;
			default: begin
				if (go)
					ref_state = st_ramp_up;
				else if (at_tick) begin
					ref_frwrd = clamp(ref_frwrd - `RAMP_STEP, 0, `FRWRD_MAX);
					ref_state = (ref_frwrd == 0) ? st_idle : st_ramp_down;
				end
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks and stimulus helpers.
	////////////////////////////////////////////////////////////////////////////
	task automatic compare_value(string name, int expected, int actual);
		if (expected != actual) begin
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "Mismatch in %s.", name);
		end
	endtask

	task automatic abort_timeout(string what);
		$display("Timed out while waiting for %s.", what);
		$display(">>> FAIL");
		$fatal(1, "Wait loop ran out of cycles.");
	endtask

	// Compare both wheels with the model on every falling edge.
	always @(negedge clk) begin
		if (chk_en) begin
			compare_value({test_name, " lft_spd"}, expect_spd(1'b1), lft_spd);
			compare_value({test_name, " rght_spd"}, expect_spd(1'b0), rght_spd);
		end
	end

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11.
	endfunction

	task automatic rand_hdg(output logic [`ERR_W-1:0] v);
		int b;
		for (b = 0; b < `ERR_W; b++) begin
			lfsr = lfsr_next(lfsr);  // One step per bit.
			v[b] = lfsr[0];
		end
	endtask

	task automatic tick();
		@(posedge clk);
		model_edge();
	endtask

	// One heading pulse, then 2 cycles for the speeds to settle.
	task automatic send_sample(logic [`ERR_W-1:0] hdg_want, logic [`ERR_W-1:0] hdg_meas);
		tick();
		desired_hdg <= hdg_want;
		heading     <= hdg_meas;
		heading_vld <= 1'b1;
		tick();
		heading_vld <= 1'b0;
		tick();
		tick();
	endtask

	task automatic wait_speeds(string what, int lft_want, int rght_want, int limit);
		int n;
		bit hit;
		hit = 1'b0;
		for (n = 0; n < limit && !hit; n++) begin
			tick();
			@(negedge clk);
			hit = (lft_spd == lft_want) && (rght_spd == rght_want);
		end
		if (!hit)
			abort_timeout(what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence.
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int                i, held, exp_l, exp_r, hi_l, hi_r;
		logic [`ERR_W-1:0] d, h;
		rst_n       = 1'b0;
		go          = 1'b0;
		heading     = '0;
		heading_vld = 1'b0;
		desired_hdg = '0;
		lfsr        = 16'd7;
		{ref_err, ref_integ, ref_state, ref_tick, ref_frwrd} = '0;
		ref_err_vld = 1'b0;
		ref_hist    = '{0, 0, 0};
		test_name   = "idle";
		repeat (4) @(posedge clk);
		rst_n  <= 1'b1;
		chk_en = 1'b1;

		for (i = 0; i < 16; i++) begin  // Stopped, motors off.
			tick();
			@(negedge clk);
			compare_value("idle lft_pwm", 0, lft_pwm);
			compare_value("idle rght_pwm", 0, rght_pwm);
		end
		for (i = 0; i < 4; i++) begin
			rand_hdg(d);
			rand_hdg(h);
			send_sample(d, h);
			@(negedge clk);
			compare_value("idle sample lft_spd", 0, lft_spd);
		end
		for (i = 0; i < 3; i++)
			send_sample('0, '0);  // Zero error fills the history.

		test_name = "ramp";
		tick();
		go <= 1'b1;
		wait_speeds("the cruise speed", `FRWRD_MAX, `FRWRD_MAX, 400);
		for (i = 0; i < 3 * `RAMP_DIV; i++)
			tick();
		@(negedge clk);
		compare_value("ramp hold", `FRWRD_MAX, lft_spd);

		test_name = "cruise";
		for (i = 0; i < 40; i++) begin
			rand_hdg(d);
			rand_hdg(h);
			send_sample(d, h);
		end

		test_name = "windup";
		for (i = 0; i < 72; i++)
			send_sample(12'h7FF, 12'h000);  // Integrator reaches its limit.
		@(negedge clk);
		compare_value("windup lft clamp", 'h3FF, lft_spd);
		held = expect_spd(1'b0);  // Model integrator is pinned at its limit.
		for (i = 0; i < 4; i++)
			send_sample(12'h7FF, 12'h000);
		@(negedge clk);
		compare_value("windup rght hold", held, rght_spd);

		test_name = "ramp_down";
		tick();
		go <= 1'b0;
		wait_speeds("the return to idle", 0, 0, 400);
		tick();
		go <= 1'b1;
		tick();
		@(negedge clk);  // First moving cycle, integrator empty.
		compare_value("restart rght_spd", ref_speed(ref_err, 0, ref_hist[2], 0, 1'b1, 1'b0),
			rght_spd);

		test_name = "pwm";
		for (i = 0; i < 3; i++)
			send_sample('0, '0);
		send_sample(12'h7FF, 12'h000);  // D term pushes the right wheel negative.
		exp_l = ref_speed(ref_err, ref_integ, ref_hist[2], `FRWRD_MAX, 1'b1, 1'b1);
		exp_r = ref_speed(ref_err, ref_integ, ref_hist[2], `FRWRD_MAX, 1'b1, 1'b0);
		wait_speeds("the held cruise speeds", exp_l, exp_r, 400);
		for (i = 0; i < `PWM_PERIOD; i++)
			tick();  // A frame boundary latches the held speeds.
		hi_l = 0;
		hi_r = 0;
		for (i = 0; i < `PWM_PERIOD; i++) begin
			tick();
			@(negedge clk);
			hi_l += lft_pwm;
			hi_r += rght_pwm;
		end
		compare_value("pwm lft high time", magnitude(exp_l), hi_l);
		compare_value("pwm lft_dir", exp_l < 0, lft_dir);
		compare_value("pwm rght high time", magnitude(exp_r), hi_r);
		compare_value("pwm rght_dir", exp_r < 0, rght_dir);

		chk_en = 1'b0;
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: tb.f
+incdir+hdl
hdl/drive_pkg.sv
hdl/pid_cmd_if.sv
hdl/heading_err.sv
hdl/move_seq.sv
hdl/pid.sv
hdl/motor_pwm.sv
hdl/drive_ctrl_top.sv
testbench/tb_drive_ctrl.sv

// File: Makefile
TOP := tb_drive_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
